//--- Bender.yml
package:
  name: lcd_ctrl

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/lcd_pkg.sv
      - design/lcd_apb_regs.sv
      - design/lcd_timing.sv
      - design/lcd_frame_ram.sv
      - design/lcd_window_fetch.sv
      - design/lcd_pixel_out.sv
      - design/lcd_ctrl_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/lcd_tb.sv

//--- design/lcd_apb_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "lcd_consts.svh"

module lcd_apb_regs (
	input wire logic pixel_clk,
	input wire logic rst,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [`LCD_APB_AW-1:0] paddr,
	input wire logic [31:0] pwdata,
	input wire logic [15:0] frame_cnt,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic ram_we,
	output logic [`LCD_RAM_AW-1:0] ram_waddr,
	output lcd_pkg::lcd_pixel_t ram_wdata,
	output lcd_pkg::lcd_coord_t win_x,
	output lcd_pkg::lcd_coord_t win_y,
	output lcd_pkg::lcd_rgb_t bg_color,
	output logic pattern_en
);

	logic access;
	logic wr_en;
	logic bad_addr;
	logic bad_wr;
	logic bad_rd;
	logic [31:0] rd_data;

	assign access = psel && penable;
	assign wr_en = access && pwrite && !bad_addr && !bad_wr;
	assign pready = 1'b1; // No wait states.

	always_comb begin
		rd_data = '0;
		bad_addr = 1'b0;
		bad_wr = 1'b0;
		bad_rd = 1'b0;
		case (paddr)
			lcd_pkg::CTRL: rd_data = {31'd0, pattern_en};
			lcd_pkg::WIN_POS: rd_data = {6'd0, win_y, 6'd0, win_x};
			lcd_pkg::BG_COLOR: rd_data = {16'd0, bg_color};
			lcd_pkg::RAM_ADDR: rd_data = {{(32-`LCD_RAM_AW){1'b0}}, ram_waddr};
			lcd_pkg::RAM_DATA: bad_rd = 1'b1;
			lcd_pkg::FRAME_CNT: begin
				rd_data = {16'd0, frame_cnt};
				bad_wr = 1'b1;
			end
			default: bad_addr = 1'b1; // Also catches unaligned offsets.
		endcase
	end

	assign prdata = (access && !pwrite) ? rd_data : '0;
	assign pslverr = access && (bad_addr || (pwrite && bad_wr) || (!pwrite && bad_rd));

	// RAM is written on the same edge that ends the access phase.
	assign ram_we = wr_en && (paddr == lcd_pkg::RAM_DATA);
	assign ram_wdata = pwdata[8:0];

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			pattern_en <= 1'b0;
			win_x <= '0;
			win_y <= '0;
			bg_color <= '0;
			ram_waddr <= '0;
		end else if (wr_en) begin
			case (paddr)
				lcd_pkg::CTRL: pattern_en <= pwdata[0];
				lcd_pkg::WIN_POS: begin
					win_x <= pwdata[9:0];
					win_y <= pwdata[25:16];
				end
				lcd_pkg::BG_COLOR: bg_color <= pwdata[15:0];
				lcd_pkg::RAM_ADDR: ram_waddr <= pwdata[`LCD_RAM_AW-1:0];
				lcd_pkg::RAM_DATA: ram_waddr <= ram_waddr + 1'b1; // Auto-increment.
				default: ;
			endcase
		end
	end

	// The master must hold address and direction through the transfer.
	a_apb_stable: assert property (@(posedge pixel_clk) disable iff (!rst)
		(psel && !penable) |=> (psel && penable && $stable(paddr) && $stable(pwrite)));

endmodule

`default_nettype wire

//--- design/lcd_consts.svh
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

// 480x272 panel, horizontal timing in pixel clocks.
`define LCD_H_ACTIVE 480
`define LCD_H_BACK   43
`define LCD_H_FRONT  8
`define LCD_H_PULSE  4

// Vertical timing in lines.
`define LCD_V_ACTIVE 272
`define LCD_V_BACK   12
`define LCD_V_FRONT  8
`define LCD_V_PULSE  4

// Sync pulse sits inside the back porch.
`define LCD_H_TOTAL (`LCD_H_BACK + `LCD_H_ACTIVE + `LCD_H_FRONT)
`define LCD_V_TOTAL (`LCD_V_BACK + `LCD_V_ACTIVE + `LCD_V_FRONT)

// Image window edge in pixels.
`define LCD_WIN_SIZE 256

// 64x64 words of 4x4 pixel blocks.
`define LCD_RAM_AW 12

// APB byte address width.
`define LCD_APB_AW 8

`endif

//--- design/lcd_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "lcd_consts.svh"

module lcd_ctrl_top (
	input wire logic pixel_clk,
	input wire logic rst,
	input wire logic psel,
	input wire logic penable,
	input wire logic pwrite,
	input wire logic [`LCD_APB_AW-1:0] paddr,
	input wire logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic lcd_clk,
	output logic lcd_hsync,
	output logic lcd_vsync,
	output logic lcd_den,
	output logic [4:0] lcd_r,
	output logic [5:0] lcd_g,
	output logic [4:0] lcd_b
);

	logic ram_we;
	logic [`LCD_RAM_AW-1:0] ram_waddr;
	logic [`LCD_RAM_AW-1:0] ram_raddr;
	lcd_pkg::lcd_pixel_t ram_wdata;
	lcd_pkg::lcd_pixel_t rdata;
	lcd_pkg::lcd_coord_t win_x;
	lcd_pkg::lcd_coord_t win_y;
	lcd_pkg::lcd_coord_t h_cnt;
	lcd_pkg::lcd_coord_t v_cnt;
	lcd_pkg::lcd_rgb_t bg_color;
	lcd_pkg::lcd_rgb_t act_bg_color;
	logic pattern_en;
	logic act_pattern_en;
	logic raw_hsync;
	logic raw_vsync;
	logic raw_den;
	logic frame_start;
	logic [15:0] frame_cnt;
	logic in_window;
	logic [15:0] pattern_sum;
	logic d_hsync;
	logic d_vsync;
	logic d_den;

	assign lcd_clk = pixel_clk; // Panel samples on the pixel clock.

	lcd_apb_regs u_regs (
		.pixel_clk(pixel_clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite),
		.paddr(paddr), .pwdata(pwdata), .frame_cnt(frame_cnt),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.ram_we(ram_we), .ram_waddr(ram_waddr), .ram_wdata(ram_wdata),
		.win_x(win_x), .win_y(win_y), .bg_color(bg_color), .pattern_en(pattern_en)
	);

	lcd_timing u_timing (
		.pixel_clk(pixel_clk), .rst(rst),
		.h_cnt(h_cnt), .v_cnt(v_cnt),
		.raw_hsync(raw_hsync), .raw_vsync(raw_vsync), .raw_den(raw_den),
		.frame_start(frame_start), .frame_cnt(frame_cnt)
	);

	lcd_frame_ram u_ram (
		.pixel_clk(pixel_clk),
		.we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
		.raddr(ram_raddr), .rdata(rdata)
	);

	lcd_window_fetch u_fetch (
		.pixel_clk(pixel_clk), .rst(rst),
		.h_cnt(h_cnt), .v_cnt(v_cnt),
		.raw_hsync(raw_hsync), .raw_vsync(raw_vsync), .raw_den(raw_den),
		.frame_start(frame_start),
		.win_x(win_x), .win_y(win_y), .bg_color(bg_color), .pattern_en(pattern_en),
		.ram_raddr(ram_raddr), .in_window(in_window), .pattern_sum(pattern_sum),
		.act_bg_color(act_bg_color), .act_pattern_en(act_pattern_en),
		.d_hsync(d_hsync), .d_vsync(d_vsync), .d_den(d_den)
	);

	lcd_pixel_out u_out (
		.pixel_clk(pixel_clk), .rst(rst),
		.rdata(rdata), .in_window(in_window), .pattern_sum(pattern_sum),
		.act_bg_color(act_bg_color), .act_pattern_en(act_pattern_en),
		.d_hsync(d_hsync), .d_vsync(d_vsync), .d_den(d_den),
		.lcd_hsync(lcd_hsync), .lcd_vsync(lcd_vsync), .lcd_den(lcd_den),
		.lcd_r(lcd_r), .lcd_g(lcd_g), .lcd_b(lcd_b)
	);

endmodule

`default_nettype wire

//--- design/lcd_frame_ram.sv
`timescale 1ns/1ns
`default_nettype none

`include "lcd_consts.svh"

module lcd_frame_ram (
	input wire logic pixel_clk,
	input wire logic we,
	input wire logic [`LCD_RAM_AW-1:0] waddr,
	input wire lcd_pkg::lcd_pixel_t wdata,
	input wire logic [`LCD_RAM_AW-1:0] raddr,
	output lcd_pkg::lcd_pixel_t rdata
);

	lcd_pkg::lcd_pixel_t mem [0:(1 << `LCD_RAM_AW)-1];

	always_ff @(posedge pixel_clk) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// One cycle read latency, part of the fixed pixel pipeline.
	always_ff @(posedge pixel_clk) begin
		rdata <= mem[raddr];
	end

endmodule

`default_nettype wire

//--- design/lcd_pixel_out.sv
`timescale 1ns/1ns
`default_nettype none

module lcd_pixel_out (
	input wire logic pixel_clk,
	input wire logic rst,
	input wire lcd_pkg::lcd_pixel_t rdata,
	input wire logic in_window,
	input wire logic [15:0] pattern_sum,
	input wire lcd_pkg::lcd_rgb_t act_bg_color,
	input wire logic act_pattern_en,
	input wire logic d_hsync,
	input wire logic d_vsync,
	input wire logic d_den,
	output logic lcd_hsync,
	output logic lcd_vsync,
	output logic lcd_den,
	output logic [4:0] lcd_r,
	output logic [5:0] lcd_g,
	output logic [4:0] lcd_b
);

	lcd_pkg::lcd_rgb_t img;
	lcd_pkg::lcd_rgb_t pix;

	// Grey word spread over all three channels.
	assign img = '{r: rdata[8:4], g: rdata[8:3], b: rdata[8:4]};

	always_comb begin
		if (!d_den) begin
			pix = '0; // Blank outside the active area.
		end else if (in_window) begin
			pix = img;
		end else if (act_pattern_en) begin
			pix = pattern_sum;
		end else begin
			pix = act_bg_color;
		end
	end

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			lcd_hsync <= 1'b1;
			lcd_vsync <= 1'b1;
			lcd_den <= 1'b0;
			{lcd_r, lcd_g, lcd_b} <= '0;
		end else begin
			lcd_hsync <= d_hsync;
			lcd_vsync <= d_vsync;
			lcd_den <= d_den;
			{lcd_r, lcd_g, lcd_b} <= pix;
		end
	end

	a_blank_rgb: assert property (@(posedge pixel_clk) disable iff (!rst)
		!lcd_den |-> ({lcd_r, lcd_g, lcd_b} == '0));

endmodule

`default_nettype wire

//--- design/lcd_pkg.sv
`default_nettype none

`include "lcd_consts.svh"

package lcd_pkg;

	// Grey level as stored in the frame RAM.
	typedef logic [8:0] lcd_pixel_t;

	// Unsigned screen coordinate.
	typedef logic [9:0] lcd_coord_t;

	// RGB565, red in the top bits.
	typedef struct packed {
		logic [4:0] r;
		logic [5:0] g;
		logic [4:0] b;
	} lcd_rgb_t;

	// APB register byte offsets.
	typedef enum logic [`LCD_APB_AW-1:0] {
		CTRL      = 'h00, // Bit 0 is pattern enable.
		WIN_POS   = 'h04, // x in 9:0, y in 25:16.
		BG_COLOR  = 'h08,
		RAM_ADDR  = 'h0C,
		RAM_DATA  = 'h10, // Write only, post-increments RAM_ADDR.
		FRAME_CNT = 'h14  // Read only.
	} lcd_reg_e;

endpackage

`default_nettype wire

//--- design/lcd_timing.sv
`timescale 1ns/1ns
`default_nettype none

`include "lcd_consts.svh"

module lcd_timing (
	input wire logic pixel_clk,
	input wire logic rst,
	output lcd_pkg::lcd_coord_t h_cnt,
	output lcd_pkg::lcd_coord_t v_cnt,
	output logic raw_hsync,
	output logic raw_vsync,
	output logic raw_den,
	output logic frame_start,
	output logic [15:0] frame_cnt
);

	logic line_end;
	logic frame_end;
	logic h_act;
	logic v_act;

	assign line_end = (h_cnt == 10'(`LCD_H_TOTAL - 1));
	assign frame_end = (v_cnt == 10'(`LCD_V_TOTAL - 1));

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (line_end) begin
			h_cnt <= '0;
			v_cnt <= frame_end ? '0 : v_cnt + 1'b1;
		end else begin
			h_cnt <= h_cnt + 1'b1;
		end
	end

	// Syncs are active low for the first few counts.
	assign raw_hsync = (h_cnt >= `LCD_H_PULSE);
	assign raw_vsync = (v_cnt >= `LCD_V_PULSE);

	assign h_act = (h_cnt >= `LCD_H_BACK) && (h_cnt < (`LCD_H_BACK + `LCD_H_ACTIVE));
	assign v_act = (v_cnt >= `LCD_V_BACK) && (v_cnt < (`LCD_V_BACK + `LCD_V_ACTIVE));
	assign raw_den = h_act && v_act;

	assign frame_start = (h_cnt == '0) && (v_cnt == '0);

	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			frame_cnt <= '0;
		end else if (frame_start) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	a_cnt_range: assert property (@(posedge pixel_clk) disable iff (!rst)
		(h_cnt < `LCD_H_TOTAL) && (v_cnt < `LCD_V_TOTAL));

endmodule

`default_nettype wire

//--- design/lcd_window_fetch.sv
`timescale 1ns/1ns
`default_nettype none

`include "lcd_consts.svh"

module lcd_window_fetch (
	input wire logic pixel_clk,
	input wire logic rst,
	input wire lcd_pkg::lcd_coord_t h_cnt,
	input wire lcd_pkg::lcd_coord_t v_cnt,
	input wire logic raw_hsync,
	input wire logic raw_vsync,
	input wire logic raw_den,
	input wire logic frame_start,
	input wire lcd_pkg::lcd_coord_t win_x,
	input wire lcd_pkg::lcd_coord_t win_y,
	input wire lcd_pkg::lcd_rgb_t bg_color,
	input wire logic pattern_en,
	output logic [`LCD_RAM_AW-1:0] ram_raddr,
	output logic in_window,
	output logic [15:0] pattern_sum,
	output lcd_pkg::lcd_rgb_t act_bg_color,
	output logic act_pattern_en,
	output logic d_hsync,
	output logic d_vsync,
	output logic d_den
);

	lcd_pkg::lcd_coord_t act_win_x;
	lcd_pkg::lcd_coord_t act_win_y;
	lcd_pkg::lcd_coord_t x;
	lcd_pkg::lcd_coord_t y;
	lcd_pkg::lcd_coord_t dx;
	lcd_pkg::lcd_coord_t dy;
	logic hit_x;
	logic hit_y;
	logic in_window_q;
	logic [15:0] pattern_sum_q;
	logic hsync_q;
	logic vsync_q;
	logic den_q;

	// Settings only change between frames.
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			act_win_x <= '0;
			act_win_y <= '0;
			act_bg_color <= '0;
			act_pattern_en <= 1'b0;
		end else if (frame_start) begin
			act_win_x <= win_x;
			act_win_y <= win_y;
			act_bg_color <= bg_color;
			act_pattern_en <= pattern_en;
		end
	end

	assign x = h_cnt - 10'(`LCD_H_BACK);
	assign y = v_cnt - 10'(`LCD_V_BACK);
	assign dx = x - act_win_x;
	assign dy = y - act_win_y;

	// Compare in 11 bits so the window end cannot wrap.
	assign hit_x = ({1'b0, x} >= {1'b0, act_win_x}) &&
		({1'b0, x} < ({1'b0, act_win_x} + 11'(`LCD_WIN_SIZE)));
	assign hit_y = ({1'b0, y} >= {1'b0, act_win_y}) &&
		({1'b0, y} < ({1'b0, act_win_y} + 11'(`LCD_WIN_SIZE)));

	always_ff @(posedge pixel_clk) begin
		ram_raddr <= {dy[7:2], dx[7:2]}; // One word per 4x4 block.
		pattern_sum_q <= 16'(h_cnt + 11'(v_cnt));
		pattern_sum <= pattern_sum_q;
	end

	// Second stage lines the flags up with the RAM read data.
	always_ff @(posedge pixel_clk or negedge rst) begin
		if (!rst) begin
			in_window_q <= 1'b0;
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
			den_q <= 1'b0;
			in_window <= 1'b0;
			d_hsync <= 1'b1;
			d_vsync <= 1'b1;
			d_den <= 1'b0;
		end else begin
			in_window_q <= hit_x && hit_y;
			hsync_q <= raw_hsync;
			vsync_q <= raw_vsync;
			den_q <= raw_den;
			in_window <= in_window_q;
			d_hsync <= hsync_q;
			d_vsync <= vsync_q;
			d_den <= den_q;
		end
	end

endmodule

`default_nettype wire

//--- test/lcd_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "lcd_consts.svh"

module lcd_tb;

	localparam int CLK_PERIOD = 40;
	localparam int FRAME_CYCLES = `LCD_H_TOTAL * `LCD_V_TOTAL;
	localparam int WATCHDOG_NS = (16 + 8 * FRAME_CYCLES) * CLK_PERIOD; // Reset plus 8 frames.
	localparam int RAM_WORDS = 1 << `LCD_RAM_AW;

	logic pixel_clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [`LCD_APB_AW-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic lcd_clk;
	logic lcd_hsync;
	logic lcd_vsync;
	logic lcd_den;
	logic [4:0] lcd_r;
	logic [5:0] lcd_g;
	logic [4:0] lcd_b;

	int errs [1:6];
	int seed;
	int pix_test;
	bit check_on;
	bit new_frame;
	int frames_seen;
	int h_pos;
	int line_no;
	int den_lines;
	logic prev_hs;
	logic prev_vs;
	logic prev_den;

	// Model of the frame RAM and of the pending and frame-latched settings.
	lcd_pkg::lcd_pixel_t shadow_ram [0:RAM_WORDS-1];
	logic [`LCD_RAM_AW-1:0] shadow_addr;
	int pend_wx;
	int pend_wy;
	lcd_pkg::lcd_rgb_t pend_bg;
	bit pend_pat;
	int act_wx;
	int act_wy;
	lcd_pkg::lcd_rgb_t act_bg;
	bit act_pat;

	lcd_ctrl_top u_dut (
		.pixel_clk(pixel_clk), .rst(rst),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.lcd_clk(lcd_clk), .lcd_hsync(lcd_hsync), .lcd_vsync(lcd_vsync), .lcd_den(lcd_den),
		.lcd_r(lcd_r), .lcd_g(lcd_g), .lcd_b(lcd_b)
	);

	initial begin
		pixel_clk = 1'b0;
		forever #(CLK_PERIOD / 2) pixel_clk = ~pixel_clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the run did not complete within %0d ns", WATCHDOG_NS);
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic lcd_pkg::lcd_rgb_t expected_rgb(input int x, input int y);
		lcd_pkg::lcd_rgb_t c;
		lcd_pkg::lcd_pixel_t grey;
		int dx;
		int dy;
		dx = x - act_wx;
		dy = y - act_wy;
		if (dx >= 0 && dx < `LCD_WIN_SIZE && dy >= 0 && dy < `LCD_WIN_SIZE) begin
			grey = shadow_ram[(dy / 4) * 64 + dx / 4]; // 64 blocks per row.
			c.r = grey[8:4];
			c.g = grey[8:3];
			c.b = grey[8:4];
		end else if (act_pat) begin
			c = 16'(x + `LCD_H_BACK + y + `LCD_V_BACK); // Sum of the raw counters.
		end else begin
			c = act_bg;
		end
		return c;
	endfunction

	task automatic compare(input int tid, input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			errs[tid]++;
			$display("error: %s = 0x%0h, expected 0x%0h (test %0d at %0t)",
				name, actual, expected, tid, $time);
		end
	endtask

	task automatic apb_xfer(input int tid, input logic wr,
		input logic [`LCD_APB_AW-1:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(negedge pixel_clk);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = wr;
		paddr = addr;
		pwdata = wdata;
		@(negedge pixel_clk);
		penable = 1'b1;
		#(CLK_PERIOD / 4);
		rdata = prdata;
		err = pslverr;
		compare(tid, "pready", pready, 32'd1); // Zero wait states.
		@(negedge pixel_clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic reg_write(input int tid, input logic [`LCD_APB_AW-1:0] addr,
		input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_xfer(tid, 1'b1, addr, data, rd, err);
		compare(tid, "pslverr", err, 32'd0);
		case (addr)
			lcd_pkg::CTRL: pend_pat = data[0];
			lcd_pkg::WIN_POS: begin
				pend_wx = data[9:0];
				pend_wy = data[25:16];
			end
			lcd_pkg::BG_COLOR: pend_bg = data[15:0];
			lcd_pkg::RAM_ADDR: shadow_addr = data[`LCD_RAM_AW-1:0];
			lcd_pkg::RAM_DATA: begin
				shadow_ram[shadow_addr] = data[8:0];
				shadow_addr = shadow_addr + 1'b1;
			end
			default: ;
		endcase
	endtask

	task automatic reg_read(input int tid, input logic [`LCD_APB_AW-1:0] addr,
		output logic [31:0] rd);
		logic err;
		apb_xfer(tid, 1'b0, addr, 32'd0, rd, err);
		compare(tid, "pslverr", err, 32'd0);
	endtask

	task automatic check_registers();
		logic [31:0] rd;
		logic err;
		reg_write(1, lcd_pkg::CTRL, 32'hFFFF_FFFF);
		reg_read(1, lcd_pkg::CTRL, rd);
		compare(1, "ctrl", rd, 32'h0000_0001);
		reg_write(1, lcd_pkg::WIN_POS, 32'hFABC_F123);
		reg_read(1, lcd_pkg::WIN_POS, rd);
		compare(1, "win_pos", rd, 32'h02BC_0123);
		reg_write(1, lcd_pkg::BG_COLOR, 32'hDEAD_BEEF);
		reg_read(1, lcd_pkg::BG_COLOR, rd);
		compare(1, "bg_color", rd, 32'h0000_BEEF);
		reg_write(1, lcd_pkg::RAM_ADDR, 32'h0000_5A5A);
		reg_read(1, lcd_pkg::RAM_ADDR, rd);
		compare(1, "ram_addr", rd, 32'h0000_0A5A);
		reg_read(1, lcd_pkg::FRAME_CNT, rd);
		compare(1, "frame_cnt", rd, 32'd1); // One frame start since reset.
		apb_xfer(1, 1'b1, lcd_pkg::FRAME_CNT, 32'h0000_FFFF, rd, err);
		compare(1, "pslverr", err, 32'd1);
		reg_read(1, lcd_pkg::FRAME_CNT, rd);
		compare(1, "frame_cnt", rd, 32'd1);
		apb_xfer(1, 1'b0, 8'h18, 32'd0, rd, err);
		compare(1, "pslverr", err, 32'd1);
		apb_xfer(1, 1'b1, 8'h06, 32'd0, rd, err); // Unaligned.
		compare(1, "pslverr", err, 32'd1);
		apb_xfer(1, 1'b0, lcd_pkg::RAM_DATA, 32'd0, rd, err);
		compare(1, "pslverr", err, 32'd1);
	endtask

	task automatic load_ram();
		logic [31:0] word;
		logic [31:0] rd;
		int i;
		reg_write(3, lcd_pkg::RAM_ADDR, 32'd0);
		for (i = 0; i < RAM_WORDS; i++) begin
			word = $random(seed);
			reg_write(3, lcd_pkg::RAM_DATA, word & 32'h0000_01FF);
		end
		reg_read(3, lcd_pkg::RAM_ADDR, rd);
		compare(3, "ram_addr", rd, 32'(shadow_addr)); // Address wrapped around.
	endtask

	task automatic wait_frames(input int n);
		int target;
		target = frames_seen + n;
		wait (frames_seen >= target);
	endtask

	task automatic report_test(input int tid, input string name);
		$display("test %0d %s: %s, %0d errors", tid, name, (errs[tid] == 0) ? "pass" : "fail",
			errs[tid]);
	endtask

	// Panel clock follows the pixel clock, sampled mid-phase.
	always @(pixel_clk) begin
		#(CLK_PERIOD / 4);
		if (check_on) begin
			compare(2, "lcd_clk", lcd_clk, pixel_clk);
		end
	end

	// Pins change on the rising edge and are sampled on the falling one.
	always @(negedge pixel_clk) begin
		if (rst) begin
			new_frame = prev_vs && !lcd_vsync;
			if (prev_hs && !lcd_hsync) begin
				if (check_on) begin
					compare(2, "hsync period", h_pos + 1, `LCD_H_TOTAL);
				end
				h_pos = 0;
				line_no = line_no + 1;
			end else begin
				h_pos = h_pos + 1;
			end
			if (check_on && !prev_hs && lcd_hsync) begin
				compare(2, "hsync low width", h_pos, `LCD_H_PULSE);
			end
			if (!prev_den && lcd_den) begin
				den_lines = den_lines + 1;
				if (check_on) begin
					compare(2, "den start", h_pos, `LCD_H_BACK);
				end
			end
			if (check_on && prev_den && !lcd_den) begin
				compare(2, "den width", h_pos - `LCD_H_BACK, `LCD_H_ACTIVE);
			end
			if (check_on && !prev_vs && lcd_vsync) begin
				compare(2, "vsync low width", line_no, `LCD_V_PULSE);
			end
			if (check_on && lcd_den) begin
				compare(pix_test, "lcd_rgb", {lcd_r, lcd_g, lcd_b},
					expected_rgb(h_pos - `LCD_H_BACK, line_no - `LCD_V_BACK));
			end
			if (new_frame) begin
				if (check_on) begin
					compare(2, "vsync period", line_no, `LCD_V_TOTAL);
					compare(2, "active lines", den_lines, `LCD_V_ACTIVE);
				end
				line_no = 0;
				den_lines = 0;
				act_wx = pend_wx; // DUT latched these three cycles earlier.
				act_wy = pend_wy;
				act_bg = pend_bg;
				act_pat = pend_pat;
			end
			prev_hs = lcd_hsync;
			prev_vs = lcd_vsync;
			prev_den = lcd_den;
			if (new_frame) begin
				frames_seen = frames_seen + 1;
			end
		end
	end

	initial begin
		logic [31:0] rd;
		logic [31:0] rnd;
		logic [15:0] cnt_first;
		logic [15:0] cnt_delta;
		int total;
		int passed;
		rst = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		seed = 32'he9b3;
		check_on = 1'b0;
		pix_test = 3;
		frames_seen = 0;
		h_pos = 0;
		line_no = 0;
		den_lines = 0;
		prev_hs = 1'b1;
		prev_vs = 1'b1;
		prev_den = 1'b0;
		shadow_addr = '0;
		pend_wx = 0;
		pend_wy = 0;
		pend_bg = '0;
		pend_pat = 1'b0;
		act_wx = 0;
		act_wy = 0;
		act_bg = '0;
		act_pat = 1'b0;
		for (int t = 1; t <= 6; t++) begin
			errs[t] = 0;
		end
		repeat (16) @(negedge pixel_clk);
		rst = 1'b1;
		wait_frames(1);
		check_registers();
		report_test(1, "register access");
		load_ram();
		reg_write(3, lcd_pkg::WIN_POS, {6'd0, 10'd8, 6'd0, 10'd160});
		reg_write(3, lcd_pkg::CTRL, 32'd0);
		rnd = $random(seed);
		reg_write(3, lcd_pkg::BG_COLOR, rnd & 32'h0000_FFFF);
		wait_frames(1);
		check_on = 1'b1;
		reg_read(6, lcd_pkg::FRAME_CNT, rd);
		cnt_first = rd[15:0];
		reg_write(3, lcd_pkg::CTRL, 32'd1); // Pattern from the next frame on.
		wait_frames(1);
		report_test(3, "window image");
		pix_test = 4;
		reg_write(4, lcd_pkg::CTRL, 32'd0);
		rnd = $random(seed);
		reg_write(4, lcd_pkg::BG_COLOR, rnd & 32'h0000_FFFF);
		wait_frames(1);
		wait (line_no >= 140);
		report_test(4, "background modes");
		pix_test = 5;
		reg_write(5, lcd_pkg::WIN_POS, {6'd0, 10'd3, 6'd0, 10'd37});
		wait_frames(2);
		check_on = 1'b0;
		report_test(5, "frame-start latching");
		report_test(2, "panel timing");
		reg_read(6, lcd_pkg::FRAME_CNT, rd);
		cnt_delta = rd[15:0] - cnt_first;
		compare(6, "frame_cnt delta", cnt_delta, 32'd4);
		report_test(6, "frame counter");
		total = 0;
		passed = 0;
		for (int t = 1; t <= 6; t++) begin
			total += errs[t];
			passed += (errs[t] == 0);
		end
		$display("%0d of 6 tests passed, %0d errors in total", passed, total);
		if (total == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/lcd_pkg.sv
design/lcd_apb_regs.sv
design/lcd_timing.sv
design/lcd_frame_ram.sv
design/lcd_window_fetch.sv
design/lcd_pixel_out.sv
design/lcd_ctrl_top.sv
test/lcd_tb.sv
